// ==== files.f ====
+incdir+hw
hw/drbg_state_pkg.sv
hw/drbg_upd_pkg.sv
hw/drbg_stage_fifo.sv
hw/drbg_upd_blk_req.sv
hw/drbg_upd_blk_collect.sv
hw/drbg_upd.sv
tb/drbg_upd_tb.sv

// ==== hw/drbg_stage_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module drbg_stage_fifo #(
  parameter type payload_t = logic
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     clr_i,
  input  wire logic     push_i,
  input  wire payload_t data_i,
  input  wire logic     pop_i,
  output logic          full_o,
  output logic          valid_o,
  output payload_t      data_o
);

  logic     valid_q;
  logic     valid_d;
  payload_t data_q;

  // push wins over pop, so push and pop together keep the entry
  assign valid_d = clr_i  ? 1'b0 :
                   push_i ? 1'b1 :
                   pop_i  ? 1'b0 :
                   valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_q <= data_i;
    end
  end

  // single entry, so full and valid coincide
  assign full_o  = valid_q;
  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

// ==== hw/drbg_state_pkg.sv ====
`default_nettype none

`include "drbg_upd_macros.svh"

package drbg_state_pkg;

  // -------------------------------------------------------------------------
  // working state of one DRBG instance
  // -------------------------------------------------------------------------

  typedef logic [`DRBG_KEY_LEN-1:0]   key_t;
  typedef logic [`DRBG_BLK_LEN-1:0]   v_t;

  // provided data, or three cipher blocks side by side
  typedef logic [`DRBG_SEED_LEN-1:0]  seed_t;

  // low field of V, incremented per block
  typedef logic [`DRBG_CTR_LEN-1:0]   ctr_t;

  // tags that ride along with every request
  typedef logic [`DRBG_CMD_W-1:0]     ccmd_t;
  typedef logic [`DRBG_INST_ID_W-1:0] inst_id_t;

endpackage

`default_nettype wire

// ==== hw/drbg_upd.sv ====
`timescale 1ns/1ps
`default_nettype none

module drbg_upd (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    enable_i,
  // update request
  input  wire logic                    req_i,
  output logic                         rdy_o,
  input  wire drbg_upd_pkg::upd_req_t  upd_req_i,
  // update result
  output logic                         ack_o,
  input  wire logic                    rdy_i,
  output drbg_upd_pkg::upd_rsp_t       upd_rsp_o,
  // entropy source halt
  input  wire logic                    es_req_i,
  output logic                         es_ack_o,
  // block cipher
  output logic                         benc_req_o,
  input  wire logic                    benc_rdy_i,
  output drbg_upd_pkg::benc_req_t      benc_req_data_o,
  input  wire logic                    benc_ack_i,
  output logic                         benc_rdy_o,
  input  wire drbg_upd_pkg::benc_ack_t benc_ack_data_i
);

  import drbg_state_pkg::*;
  import drbg_upd_pkg::*;

  logic      fifo_clr;
  logic      updreq_push, updreq_pop, updreq_full, updreq_valid;
  upd_req_t  updreq_data;
  logic      bencreq_push, bencreq_pop, bencreq_full, bencreq_valid;
  benc_req_t bencreq_wdata;
  logic      bencack_push, bencack_pop, bencack_full, bencack_valid;
  benc_ack_t bencack_data;
  logic      pdata_push, pdata_pop, pdata_full, pdata_valid;
  seed_t     pdata_data;
  logic      final_push, final_pop, final_full, final_valid;
  upd_rsp_t  final_wdata;

  // disable flushes every stage
  assign fifo_clr = !enable_i;

  // ---------------------------------------------------------------------------
  // port side strobes
  // ---------------------------------------------------------------------------

  assign updreq_push  = req_i && !updreq_full;
  assign rdy_o        = !updreq_full;

  assign benc_req_o   = bencreq_valid;
  assign bencreq_pop  = bencreq_valid && benc_rdy_i;

  assign bencack_push = benc_ack_i && !bencack_full;
  assign benc_rdy_o   = !bencack_full;

  assign final_pop    = final_valid && rdy_i;
  assign ack_o        = final_pop;

  // ---------------------------------------------------------------------------
  // staging buffers
  // ---------------------------------------------------------------------------

  drbg_stage_fifo #(.payload_t(upd_req_t)) u_updreq (
    .clk_i, .rst_ni, .clr_i(fifo_clr),
    .push_i(updreq_push), .data_i(upd_req_i), .pop_i(updreq_pop),
    .full_o(updreq_full), .valid_o(updreq_valid), .data_o(updreq_data)
  );

  drbg_stage_fifo #(.payload_t(benc_req_t)) u_bencreq (
    .clk_i, .rst_ni, .clr_i(fifo_clr),
    .push_i(bencreq_push), .data_i(bencreq_wdata), .pop_i(bencreq_pop),
    .full_o(bencreq_full), .valid_o(bencreq_valid), .data_o(benc_req_data_o)
  );

  drbg_stage_fifo #(.payload_t(benc_ack_t)) u_bencack (
    .clk_i, .rst_ni, .clr_i(fifo_clr),
    .push_i(bencack_push), .data_i(benc_ack_data_i), .pop_i(bencack_pop),
    .full_o(bencack_full), .valid_o(bencack_valid), .data_o(bencack_data)
  );

  // carries pdata past the cipher
  drbg_stage_fifo #(.payload_t(seed_t)) u_pdata (
    .clk_i, .rst_ni, .clr_i(fifo_clr),
    .push_i(pdata_push), .data_i(updreq_data.pdata), .pop_i(pdata_pop),
    .full_o(pdata_full), .valid_o(pdata_valid), .data_o(pdata_data)
  );

  drbg_stage_fifo #(.payload_t(upd_rsp_t)) u_final (
    .clk_i, .rst_ni, .clr_i(fifo_clr),
    .push_i(final_push), .data_i(final_wdata), .pop_i(final_pop),
    .full_o(final_full), .valid_o(final_valid), .data_o(upd_rsp_o)
  );

  // ---------------------------------------------------------------------------
  // engines
  // ---------------------------------------------------------------------------

  drbg_upd_blk_req u_blk_req (
    .clk_i, .rst_ni, .enable_i, .es_req_i, .es_ack_o,
    .updreq_valid_i(updreq_valid), .updreq_i(updreq_data), .updreq_pop_o(updreq_pop),
    .bencreq_full_i(bencreq_full), .bencreq_push_o(bencreq_push), .bencreq_o(bencreq_wdata),
    .pdata_full_i(pdata_full), .pdata_push_o(pdata_push)
  );

  drbg_upd_blk_collect u_blk_collect (
    .clk_i, .rst_ni, .enable_i,
    .bencack_valid_i(bencack_valid), .bencack_i(bencack_data), .bencack_pop_o(bencack_pop),
    .pdata_valid_i(pdata_valid), .pdata_i(pdata_data), .pdata_pop_o(pdata_pop),
    .final_full_i(final_full), .final_push_o(final_push), .final_o(final_wdata)
  );

endmodule

`default_nettype wire

// ==== hw/drbg_upd_blk_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "drbg_upd_macros.svh"

module drbg_upd_blk_collect (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    enable_i,
  // cipher response buffer
  input  wire logic                    bencack_valid_i,
  input  wire drbg_upd_pkg::benc_ack_t bencack_i,
  output logic                         bencack_pop_o,
  // provided data buffer
  input  wire logic                    pdata_valid_i,
  input  wire drbg_state_pkg::seed_t   pdata_i,
  output logic                         pdata_pop_o,
  // result buffer
  input  wire logic                    final_full_i,
  output logic                         final_push_o,
  output drbg_upd_pkg::upd_rsp_t       final_o
);

  import drbg_state_pkg::*;
  import drbg_upd_pkg::*;

  typedef enum logic [1:0] {
    col_idle,
    col_load,
    col_shift
  } col_state_e;

  col_state_e state_q;
  col_state_e state_d;
  blk_cnt_t   cnt_q;
  blk_cnt_t   cnt_d;
  logic       cnt_done;
  logic       shift_blk;
  seed_t      concat_q;
  seed_t      seed_xor;
  inst_id_t   inst_id_q;
  ccmd_t      ccmd_q;

  assign cnt_done = (cnt_q >= blk_cnt_t'(`DRBG_BLKS_PER_SEED));

  assign cnt_d = !enable_i     ? '0 :
                 cnt_done      ? '0 :
                 bencack_pop_o ? cnt_q + blk_cnt_t'(1) :
                 cnt_q;

  // ---------------------------------------------------------------------------
  // collect FSM
  // ---------------------------------------------------------------------------

  always_comb begin
    state_d       = state_q;
    shift_blk     = 1'b0;
    bencack_pop_o = 1'b0;
    pdata_pop_o   = 1'b0;
    final_push_o  = 1'b0;
    unique case (state_q)
      col_idle: begin
        if (enable_i && bencack_valid_i && pdata_valid_i && !final_full_i) begin
          state_d = col_load;
        end
      end
      col_load: begin
        if (!enable_i) begin
          state_d = col_idle;
        end else if (bencack_valid_i) begin
          bencack_pop_o = 1'b1;
          state_d       = col_shift;
        end
      end
      col_shift: begin
        if (!enable_i) begin
          state_d = col_idle;
        end else if (cnt_done) begin
          // all three blocks in place
          pdata_pop_o  = 1'b1;
          final_push_o = 1'b1;
          state_d      = col_idle;
        end else begin
          shift_blk = 1'b1;
          state_d   = col_load;
        end
      end
      default: begin
        state_d = col_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= col_idle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // ---------------------------------------------------------------------------
  // concatenation, first block ends up on top
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!enable_i) begin
      concat_q  <= '0;
      inst_id_q <= '0;
      ccmd_q    <= '0;
    end else if (bencack_pop_o) begin
      concat_q  <= {concat_q[`DRBG_SEED_LEN-1:`DRBG_BLK_LEN], bencack_i.v};
      inst_id_q <= bencack_i.inst_id;
      ccmd_q    <= bencack_i.ccmd;
    end else if (shift_blk) begin
      concat_q <= {concat_q[`DRBG_SEED_LEN-`DRBG_BLK_LEN-1:0], {`DRBG_BLK_LEN{1'b0}}};
    end
  end

  // new key on top, new V below
  assign seed_xor = concat_q ^ pdata_i;

  assign final_o = '{
    key:     seed_xor[`DRBG_SEED_LEN-1:`DRBG_BLK_LEN],
    v:       seed_xor[`DRBG_BLK_LEN-1:0],
    inst_id: inst_id_q,
    ccmd:    ccmd_q
  };

endmodule

`default_nettype wire

// ==== hw/drbg_upd_blk_req.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "drbg_upd_macros.svh"

module drbg_upd_blk_req (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   enable_i,
  // entropy source halt
  input  wire logic                   es_req_i,
  output logic                        es_ack_o,
  // staged update request
  input  wire logic                   updreq_valid_i,
  input  wire drbg_upd_pkg::upd_req_t updreq_i,
  output logic                        updreq_pop_o,
  // cipher request buffer
  input  wire logic                   bencreq_full_i,
  output logic                        bencreq_push_o,
  output drbg_upd_pkg::benc_req_t     bencreq_o,
  // provided data buffer
  input  wire logic                   pdata_full_i,
  output logic                        pdata_push_o
);

  import drbg_state_pkg::*;
  import drbg_upd_pkg::*;

  typedef enum logic [1:0] {
    req_idle,
    req_send,
    req_halt
  } req_state_e;

  req_state_e state_q;
  req_state_e state_d;
  ctr_t       ctr_q;
  ctr_t       ctr_d;
  blk_cnt_t   iter_q;
  blk_cnt_t   iter_d;
  ctr_t       ctr_first;
  v_t         v_blk;
  logic       iter_done;

  // ---------------------------------------------------------------------------
  // counter blocks
  // ---------------------------------------------------------------------------

  // first block is V + 1, the counter field wraps on its own
  assign ctr_first = updreq_i.v[`DRBG_CTR_LEN-1:0] + ctr_t'(1);

  // upper 96 bits of V never change
  assign v_blk = {updreq_i.v[`DRBG_BLK_LEN-1:`DRBG_CTR_LEN], ctr_q};

  assign bencreq_o = '{
    key:     updreq_i.key,
    v:       v_blk,
    inst_id: updreq_i.inst_id,
    ccmd:    updreq_i.ccmd
  };

  // load on start, step once per pushed block
  assign ctr_d = !enable_i      ? '0 :
                 pdata_push_o   ? ctr_first :
                 bencreq_push_o ? ctr_q + ctr_t'(1) :
                 ctr_q;

  assign iter_done = (iter_q >= blk_cnt_t'(`DRBG_BLKS_PER_SEED));

  assign iter_d = !enable_i      ? '0 :
                  iter_done      ? '0 :
                  bencreq_push_o ? iter_q + blk_cnt_t'(1) :
                  iter_q;

  // ---------------------------------------------------------------------------
  // request FSM
  // ---------------------------------------------------------------------------

  always_comb begin
    state_d        = state_q;
    es_ack_o       = 1'b0;
    updreq_pop_o   = 1'b0;
    bencreq_push_o = 1'b0;
    pdata_push_o   = 1'b0;
    unique case (state_q)
      req_idle: begin
        // halt first, the entropy source must not wait behind updates
        if (es_req_i) begin
          state_d = req_halt;
        end else if (enable_i && updreq_valid_i && !bencreq_full_i && !pdata_full_i) begin
          pdata_push_o = 1'b1;
          state_d      = req_send;
        end
      end
      req_send: begin
        if (!enable_i) begin
          state_d = req_idle;
        end else if (!iter_done) begin
          bencreq_push_o = !bencreq_full_i;
        end else begin
          updreq_pop_o = 1'b1;
          state_d      = req_idle;
        end
      end
      req_halt: begin
        es_ack_o = 1'b1;
        if (!es_req_i) begin
          state_d = req_idle;
        end
      end
      default: begin
        state_d = req_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= req_idle;
      ctr_q   <= '0;
      iter_q  <= '0;
    end else begin
      state_q <= state_d;
      ctr_q   <= ctr_d;
      iter_q  <= iter_d;
    end
  end

endmodule

`default_nettype wire

// ==== hw/drbg_upd_macros.svh ====
`ifndef DRBG_UPD_MACROS_SVH
`define DRBG_UPD_MACROS_SVH

// ---------------------------------------------------------------------------
// AES-256 CTR_DRBG geometry
// ---------------------------------------------------------------------------

// cipher block, also the width of V
`define DRBG_BLK_LEN       128
`define DRBG_KEY_LEN       256
// key plus V
`define DRBG_SEED_LEN      384
// low field of V that counts
`define DRBG_CTR_LEN       32

// request tags
`define DRBG_CMD_W         3
`define DRBG_INST_ID_W     4

`define DRBG_BLKS_PER_SEED 3

`endif

// ==== hw/drbg_upd_pkg.sv ====
`default_nettype none

`include "drbg_upd_macros.svh"

package drbg_upd_pkg;

  import drbg_state_pkg::*;

  // counts cipher blocks within one update, needs to reach the block count
  typedef logic [$clog2(`DRBG_BLKS_PER_SEED+1)-1:0] blk_cnt_t;

  // -------------------------------------------------------------------------
  // payloads between the stages
  // -------------------------------------------------------------------------

  // update request as it arrives at the port
  typedef struct packed {
    key_t     key;
    v_t       v;
    seed_t    pdata;
    inst_id_t inst_id;
    ccmd_t    ccmd;
  } upd_req_t;

  // one counter block for the cipher
  typedef struct packed {
    key_t     key;
    v_t       v;
    inst_id_t inst_id;
    ccmd_t    ccmd;
  } benc_req_t;

  // cipher output, v holds the encrypted block
  typedef struct packed {
    v_t       v;
    inst_id_t inst_id;
    ccmd_t    ccmd;
  } benc_ack_t;

  // new working state
  typedef struct packed {
    key_t     key;
    v_t       v;
    inst_id_t inst_id;
    ccmd_t    ccmd;
  } upd_rsp_t;

endpackage

`default_nettype wire

// ==== tb/drbg_upd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "drbg_upd_macros.svh"

module drbg_upd_tb;

  import drbg_state_pkg::*;
  import drbg_upd_pkg::*;

  localparam int          half_period = 20;
  localparam int          drive_dly   = 2;
  localparam int          timeout_cyc = 2000;
  localparam logic [31:0] seed        = 32'he4a1;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      enable_i;
  logic      req_i;
  logic      rdy_o;
  upd_req_t  upd_req_i;
  logic      ack_o;
  logic      rdy_i;
  upd_rsp_t  upd_rsp_o;
  logic      es_req_i;
  logic      es_ack_o;
  logic      benc_req_o;
  logic      benc_rdy_i;
  benc_req_t benc_req_data_o;
  logic      benc_ack_i;
  logic      benc_rdy_o;
  benc_ack_t benc_ack_data_i;

  // expected traffic and the responses the cipher stand-in still owes
  benc_req_t   exp_benc_q[$];
  upd_rsp_t    exp_rsp_q[$];
  benc_ack_t   cipher_q[$];
  int          cipher_due_q[$];

  int          cyc        = 0;
  logic        prev_ack   = 1'b0;
  logic        full_speed = 1'b1;
  logic [31:0] stim_rng   = seed;
  logic [31:0] env_rng    = seed ^ 32'h9e37_79b9;

  drbg_upd dut (
    .clk_i, .rst_ni, .enable_i, .req_i, .rdy_o, .upd_req_i,
    .ack_o, .rdy_i, .upd_rsp_o, .es_req_i, .es_ack_o,
    .benc_req_o, .benc_rdy_i, .benc_req_data_o,
    .benc_ack_i, .benc_rdy_o, .benc_ack_data_i
  );

  always #half_period clk_i = ~clk_i;

  // ---------------------------------------------------------------------------
  // random numbers
  // ---------------------------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] stim_word();
    stim_rng = lcg_next(stim_rng);
    return stim_rng;
  endfunction

  function automatic logic [31:0] env_word();
    env_rng = lcg_next(env_rng);
    return env_rng;
  endfunction

  // upper half of the LCG word mixes best
  function automatic int below(input logic [31:0] word, input int n);
    return int'(word[31:16]) % n;
  endfunction

  function automatic upd_req_t random_request();
    upd_req_t    r;
    logic [31:0] word;
    int          i;
    for (i = 0; i < `DRBG_KEY_LEN / 32; i++) begin
      r.key[i*32 +: 32] = stim_word();
    end
    for (i = 0; i < `DRBG_BLK_LEN / 32; i++) begin
      r.v[i*32 +: 32] = stim_word();
    end
    for (i = 0; i < `DRBG_SEED_LEN / 32; i++) begin
      r.pdata[i*32 +: 32] = stim_word();
    end
    word      = stim_word();
    r.inst_id = word[31:28];
    r.ccmd    = word[27:25];
    return r;
  endfunction

  // ---------------------------------------------------------------------------
  // reference model
  // ---------------------------------------------------------------------------

  // counter block idx of an update has V plus idx in the low field only
  function automatic benc_req_t expected_block(input upd_req_t r, input int idx);
    benc_req_t b;
    ctr_t      ctr;
    ctr       = r.v[`DRBG_CTR_LEN-1:0] + ctr_t'(idx);
    b.key     = r.key;
    b.v       = {r.v[`DRBG_BLK_LEN-1:`DRBG_CTR_LEN], ctr};
    b.inst_id = r.inst_id;
    b.ccmd    = r.ccmd;
    return b;
  endfunction

  // stand-in for the block cipher
  function automatic v_t cipher_out(input key_t key, input v_t v);
    return v ^ key[`DRBG_KEY_LEN-1:`DRBG_BLK_LEN] ^ key[`DRBG_BLK_LEN-1:0];
  endfunction

  function automatic upd_rsp_t expected_result(input upd_req_t r);
    seed_t     cat;
    benc_req_t blk;
    upd_rsp_t  rsp;
    int        i;
    cat = '0;
    for (i = 1; i <= `DRBG_BLKS_PER_SEED; i++) begin
      blk = expected_block(r, i);
      cat = {cat[`DRBG_SEED_LEN-`DRBG_BLK_LEN-1:0], cipher_out(blk.key, blk.v)};
    end
    cat         = cat ^ r.pdata;
    rsp.key     = cat[`DRBG_SEED_LEN-1:`DRBG_BLK_LEN];
    rsp.v       = cat[`DRBG_BLK_LEN-1:0];
    rsp.inst_id = r.inst_id;
    rsp.ccmd    = r.ccmd;
    return rsp;
  endfunction

  // ---------------------------------------------------------------------------
  // checks
  // ---------------------------------------------------------------------------

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_rsp(input upd_rsp_t got, input upd_rsp_t exp);
    if (got.key !== exp.key) begin
      report_failure($sformatf("CHECK FAILED at %0t: result key %h, expected %h",
                               $time, got.key, exp.key));
    end
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED at %0t: result v %h id %h cmd %h, expected %h %h %h",
                               $time, got.v, got.inst_id, got.ccmd,
                               exp.v, exp.inst_id, exp.ccmd));
    end
  endtask

  task automatic check_benc(input benc_req_t got, input benc_req_t exp);
    if (got.key !== exp.key) begin
      report_failure($sformatf("CHECK FAILED at %0t: cipher key %h, expected %h",
                               $time, got.key, exp.key));
    end
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED at %0t: cipher v %h id %h cmd %h, expected %h %h %h",
                               $time, got.v, got.inst_id, got.ccmd,
                               exp.v, exp.inst_id, exp.ccmd));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                               $time, what, got, exp));
    end
  endtask

  // ---------------------------------------------------------------------------
  // cipher stand-in and port environment driven after the rising edge
  // ---------------------------------------------------------------------------

  always @(posedge clk_i) begin
    cyc = cyc + 1;
    #drive_dly;
    if (full_speed) begin
      benc_rdy_i = 1'b1;
      rdy_i      = 1'b1;
    end else begin
      benc_rdy_i = (below(env_word(), 4) != 0);
      rdy_i      = (below(env_word(), 3) != 0);
    end
    if (cipher_q.size() > 0 && cipher_due_q[0] <= cyc) begin
      benc_ack_i      = 1'b1;
      benc_ack_data_i = cipher_q[0];
    end else begin
      benc_ack_i = 1'b0;
    end
  end

  // monitor samples mid-cycle where every signal is settled
  always @(negedge clk_i) begin
    benc_ack_t resp;
    int        i;
    if (rst_ni && !enable_i) begin
      // disable drops everything in flight including the cipher
      exp_benc_q.delete();
      exp_rsp_q.delete();
      cipher_q.delete();
      cipher_due_q.delete();
      prev_ack = 1'b0;
      if (ack_o) begin
        report_failure("ack_o is high while the core is disabled");
      end
    end else if (rst_ni) begin
      if (req_i && rdy_o) begin
        for (i = 1; i <= `DRBG_BLKS_PER_SEED; i++) begin
          exp_benc_q.push_back(expected_block(upd_req_i, i));
        end
        exp_rsp_q.push_back(expected_result(upd_req_i));
      end
      if (benc_req_o && benc_rdy_i) begin
        if (exp_benc_q.size() == 0) begin
          report_failure("a cipher request appeared with no update pending");
        end
        check_benc(benc_req_data_o, exp_benc_q.pop_front());
        resp.v       = cipher_out(benc_req_data_o.key, benc_req_data_o.v);
        resp.inst_id = benc_req_data_o.inst_id;
        resp.ccmd    = benc_req_data_o.ccmd;
        cipher_q.push_back(resp);
        cipher_due_q.push_back(cyc + (full_speed ? 0 : below(env_word(), 6)));
      end
      if (benc_ack_i && benc_rdy_o) begin
        void'(cipher_q.pop_front());
        void'(cipher_due_q.pop_front());
      end
      if (ack_o) begin
        if (prev_ack) begin
          report_failure("ack_o stayed high for two cycles in a row");
        end
        if (exp_rsp_q.size() == 0) begin
          report_failure("ack_o rose with no update pending");
        end
        check_rsp(upd_rsp_o, exp_rsp_q.pop_front());
      end
      prev_ack = ack_o;
    end
  end

  // ---------------------------------------------------------------------------
  // stimulus helpers
  // ---------------------------------------------------------------------------

  task automatic next_cycle();
    @(posedge clk_i);
    #drive_dly;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic set_mode(input logic fast);
    @(posedge clk_i);
    full_speed = fast;
    #drive_dly;
  endtask

  task automatic send_update(input upd_req_t r);
    int waited;
    waited    = 0;
    upd_req_i = r;
    req_i     = 1'b1;
    @(negedge clk_i);
    while (rdy_o !== 1'b1) begin
      waited++;
      if (waited > timeout_cyc) begin
        report_failure("timeout: the update request was never accepted");
      end
      @(negedge clk_i);
    end
    next_cycle();
    req_i = 1'b0;
  endtask

  task automatic wait_results();
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (exp_rsp_q.size() != 0) begin
      waited++;
      if (waited > timeout_cyc) begin
        report_failure("timeout: update results did not arrive");
      end
      @(posedge clk_i);
    end
    #drive_dly;
  endtask

  task automatic wait_es_ack();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (es_ack_o !== 1'b1) begin
      waited++;
      if (waited > timeout_cyc) begin
        report_failure("timeout: es_ack_o never rose after es_req_i");
      end
      @(negedge clk_i);
    end
    next_cycle();
  endtask

  task automatic wait_cipher_take();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!(benc_req_o && benc_rdy_i)) begin
      waited++;
      if (waited > timeout_cyc) begin
        report_failure("timeout: no cipher request was taken");
      end
      @(negedge clk_i);
    end
    next_cycle();
  endtask

  // ---------------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------------

  initial begin
    upd_req_t r;
    int       i;
    rst_ni          = 1'b0;
    enable_i        = 1'b0;
    req_i           = 1'b0;
    upd_req_i       = '0;
    es_req_i        = 1'b0;
    rdy_i           = 1'b1;
    benc_rdy_i      = 1'b1;
    benc_ack_i      = 1'b0;
    benc_ack_data_i = '0;

    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    check_bit(rdy_o, 1'b1, "rdy_o in reset");
    check_bit(benc_rdy_o, 1'b1, "benc_rdy_o in reset");
    check_bit(ack_o, 1'b0, "ack_o in reset");
    check_bit(benc_req_o, 1'b0, "benc_req_o in reset");
    check_bit(es_ack_o, 1'b0, "es_ack_o in reset");
    next_cycle();
    rst_ni   = 1'b1;
    enable_i = 1'b1;
    idle_cycles(2);

    // single update without back-pressure
    send_update(random_request());
    wait_results();
    idle_cycles(4);

    // counter field close to wrapping
    r = random_request();
    r.v[`DRBG_CTR_LEN-1:0] = 32'hffff_fffe;
    send_update(r);
    r = random_request();
    r.v[`DRBG_CTR_LEN-1:0] = '1;
    send_update(r);
    wait_results();

    // random traffic with back-pressure on both sides
    set_mode(1'b0);
    for (i = 0; i < 40; i++) begin
      send_update(random_request());
      idle_cycles(below(stim_word(), 4));
    end
    wait_results();
    set_mode(1'b1);

    // entropy source halt holds back a queued update
    es_req_i = 1'b1;
    wait_es_ack();
    send_update(random_request());
    for (i = 0; i < 20; i++) begin
      @(negedge clk_i);
      check_bit(es_ack_o, 1'b1, "es_ack_o during halt");
      check_bit(benc_req_o, 1'b0, "benc_req_o during halt");
    end
    next_cycle();
    es_req_i = 1'b0;
    wait_results();
    @(negedge clk_i);
    check_bit(es_ack_o, 1'b0, "es_ack_o after halt");
    next_cycle();

    // disable in the middle of an update
    send_update(random_request());
    wait_cipher_take();
    enable_i = 1'b0;
    idle_cycles(2);
    @(negedge clk_i);
    check_bit(rdy_o, 1'b1, "rdy_o after clear");
    check_bit(benc_rdy_o, 1'b1, "benc_rdy_o after clear");
    check_bit(benc_req_o, 1'b0, "benc_req_o after clear");
    next_cycle();
    enable_i = 1'b1;
    next_cycle();
    send_update(random_request());
    wait_results();
    idle_cycles(4);

    if (exp_rsp_q.size() != 0 || cipher_q.size() != 0) begin
      report_failure("updates were still outstanding at the end of the run");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
